// File: source/fleetPkg.sv
package fleetPkg;

	// ******************************
	// Board geometry
	// ******************************

	// One board coordinate
	typedef logic [3:0] coord_t;

	// A single board cell
	typedef struct packed
	{
		coord_t coordX;
		coord_t coordY;
	} cell_t;

	// Largest ship is the carrier
	localparam int MaxCells = 5;

	// ******************************
	// Ships and requests
	// ******************************

	// Codes 5 to 7 are not ships and fail the board check
	typedef enum logic [2:0]
	{
		submarine  = 3'd0,
		cruiser    = 3'd1,
		seaplane   = 3'd2,
		battleship = 3'd3,
		carrier    = 3'd4
	} shipType_e;

	// Valid cells in a record, 0 to 5
	typedef logic [2:0] cellCount_t;

	// Stored ship with unused cells at zero
	typedef struct packed
	{
		shipType_e               shipType;
		cellCount_t              count;
		cell_t [MaxCells-1:0]    cells;
	} shipRecord_t;

	// Placement request as held by the requester
	typedef struct packed
	{
		logic      player;
		shipType_e shipType;
		cell_t     anchor;
		logic      vertical;
		logic      flip;
	} placeReq_t;

	// Slot index in the fleet memory of one player
	typedef logic [4:0] slotAddr_t;

endpackage

// File: source/shipShaper.sv
`timescale 1ns/1ps

module shipShaper
	import fleetPkg::*;
#(
	parameter int GridSize = 9
)
(
	input  logic        clk,
	input  logic        rstN,
	input  logic        shapeLoad,
	input  placeReq_t   req,
	output shipRecord_t shipRec,
	output logic        inBounds
);

	shipRecord_t nextRec;
	logic        nextInBounds;

	// ******************************
	// Cell layout
	// ******************************
	always_comb
	begin
		int dx;
		int dy;
		int cellX;
		int cellY;

		nextRec = '0;
		nextRec.shipType = req.shipType;
		nextInBounds = 1'b1;

		case (req.shipType)
			submarine:  nextRec.count = 3'd1;
			cruiser:    nextRec.count = 3'd2;
			seaplane:   nextRec.count = 3'd3;
			battleship: nextRec.count = 3'd4;
			carrier:    nextRec.count = 3'd5;
			default:
			begin
				// Unknown type codes fail the board check
				nextRec.count = 3'd0;
				nextInBounds = 1'b0;
			end
		endcase

		for (int i = 0; i < MaxCells; i++)
		begin
			dx = 0;
			dy = 0;
			if (req.shipType == seaplane)
			begin
				// Middle cell steps to the side picked by flip
				case (i)
					1:
					begin
						if (req.vertical)
						begin
							dx = req.flip ? -1 : 1;
							dy = 1;
						end
						else
						begin
							dx = 1;
							dy = req.flip ? -1 : 1;
						end
					end
					2:
					begin
						dx = req.vertical ? 0 : 2;
						dy = req.vertical ? 2 : 0;
					end
					default:
					begin
						dx = 0;
						dy = 0;
					end
				endcase
			end
			else
			begin
				// Straight ships grow along +x or +y
				dx = req.vertical ? 0 : i;
				dy = req.vertical ? i : 0;
			end

			cellX = int'(req.anchor.coordX) + dx;
			cellY = int'(req.anchor.coordY) + dy;

			if (i < int'(nextRec.count))
			begin
				nextRec.cells[i].coordX = coord_t'(cellX);
				nextRec.cells[i].coordY = coord_t'(cellY);
				if (cellX < 0 || cellX >= GridSize || cellY < 0 || cellY >= GridSize)
					nextInBounds = 1'b0;
			end
		end
	end

	// Ship record of the current request
	always_ff @(posedge clk)
	begin
		if (shapeLoad)
			shipRec <= nextRec;
	end

	always_ff @(posedge clk)
	begin
		if (!rstN)
			inBounds <= 1'b0;
		else if (shapeLoad)
			inBounds <= nextInBounds;
	end

endmodule

// File: source/overlapScanner.sv
`timescale 1ns/1ps

module overlapScanner
	import fleetPkg::*;
(
	input  logic        clk,
	input  logic        rstN,
	input  logic        scanStart,
	input  shipRecord_t shipRec,
	input  slotAddr_t   fleetSize,
	input  shipRecord_t readRecord,
	output slotAddr_t   memAddr,
	output logic        scanDone,
	output logic        hit
);

	logic      busy;
	logic      dataValid;
	logic      lastData;
	logic      emptyDone;
	logic      hitReg;
	logic      matchNow;
	slotAddr_t scanLimit;

	// Any valid cell of one record on any valid cell of the other
	function automatic logic sharesCell(shipRecord_t a, shipRecord_t b);
		logic found;
		found = 1'b0;
		for (int i = 0; i < MaxCells; i++)
		begin
			for (int j = 0; j < MaxCells; j++)
			begin
				if (i < int'(a.count) && j < int'(b.count) && a.cells[i] == b.cells[j])
					found = 1'b1;
			end
		end
		return found;
	endfunction

	assign matchNow = dataValid && sharesCell(shipRec, readRecord);
	assign scanDone = emptyDone || (dataValid && (matchNow || lastData));
	assign hit = hitReg || matchNow;

	// ******************************
	// Read pipeline
	// ******************************
	// Record returns one cycle after its address
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			busy <= 1'b0;
			dataValid <= 1'b0;
			lastData <= 1'b0;
			emptyDone <= 1'b0;
			hitReg <= 1'b0;
			memAddr <= '0;
		end
		else if (scanStart)
		begin
			memAddr <= '0;
			busy <= (fleetSize != '0);
			emptyDone <= (fleetSize == '0);
			dataValid <= 1'b0;
			lastData <= 1'b0;
			hitReg <= 1'b0;
		end
		else
		begin
			emptyDone <= 1'b0;
			if (matchNow)
				hitReg <= 1'b1;
			if (scanDone)
			begin
				// Early stop on a hit or on the last slot
				busy <= 1'b0;
				dataValid <= 1'b0;
			end
			else if (busy)
			begin
				dataValid <= 1'b1;
				lastData <= (memAddr == scanLimit - 1'b1);
				if (memAddr == scanLimit - 1'b1)
					busy <= 1'b0;
				else
					memAddr <= memAddr + 1'b1;
			end
			else
				dataValid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (scanStart)
			scanLimit <= fleetSize;
	end

	// Every returned record came from a slot that holds a ship
	assert property (@(posedge clk) disable iff (!rstN)
		dataValid |-> $past(memAddr) < fleetSize);

endmodule

// File: source/fleetCounter.sv
`timescale 1ns/1ps

module fleetCounter
	import fleetPkg::*;
#(
	parameter int MaxShips = 20
)
(
	input  logic      clk,
	input  logic      rstN,
	input  logic      player,
	input  logic      advance,
	output slotAddr_t fleetSize
);

	// Next free slot of each player
	slotAddr_t slotPtr [2];

	assign fleetSize = slotPtr[player];

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			slotPtr[0] <= '0;
			slotPtr[1] <= '0;
		end
		else if (advance)
			slotPtr[player] <= slotPtr[player] + 1'b1;
	end

	// No write once a fleet is full
	assert property (@(posedge clk) disable iff (!rstN)
		advance |-> int'(fleetSize) < MaxShips);

endmodule

// File: source/placementControl.sv
`timescale 1ns/1ps

module placementControl
(
	input  logic clk,
	input  logic rstN,
	input  logic enable,
	input  logic inBounds,
	input  logic scanDone,
	input  logic hit,
	output logic shapeLoad,
	output logic scanStart,
	output logic writeEn,
	output logic accepted,
	output logic borderConflict,
	output logic overlapConflict,
	output logic conflict
);

	typedef enum logic [2:0]
	{
		idle,
		shaping,
		boundCheck,
		scanning,
		borderReject,
		overlapReject,
		saving,
		holding
	} state_e;

	state_e state;
	state_e nextState;

	always_ff @(posedge clk)
	begin
		if (!rstN)
			state <= idle;
		else
			state <= nextState;
	end

	// ******************************
	// Next state
	// ******************************
	always_comb
	begin
		nextState = state;
		case (state)
			idle:
				if (enable)
					nextState = shaping;
			shaping:
				nextState = enable ? boundCheck : idle;
			boundCheck:
			begin
				if (!enable)
					nextState = idle;
				else if (!inBounds)
					nextState = borderReject;
				else
					nextState = scanning;
			end
			scanning:
			begin
				if (!enable)
					nextState = idle;
				else if (scanDone)
					nextState = hit ? overlapReject : saving;
			end
			// Write already issued, so saving never returns to scanning
			saving:
				nextState = enable ? holding : idle;
			default:
				if (!enable)
					nextState = idle;
		endcase
	end

	// Strobes and result levels straight from the state
	assign shapeLoad = (state == shaping);
	assign scanStart = (state == boundCheck) && inBounds;
	assign writeEn = (state == saving);
	assign accepted = (state == saving) || (state == holding);
	assign borderConflict = (state == borderReject);
	assign overlapConflict = (state == overlapReject);
	assign conflict = borderConflict || overlapConflict;

	// Only one kind of conflict per request
	assert property (@(posedge clk) disable iff (!rstN)
		!(borderConflict && overlapConflict));

endmodule

// File: source/shipValidator.sv
`timescale 1ns/1ps

module shipValidator
	import fleetPkg::*;
#(
	parameter int GridSize = 9,
	parameter int MaxShips = 20
)
(
	input  logic        clk,
	input  logic        rstN,
	input  logic        enable,
	input  placeReq_t   req,
	input  shipRecord_t readRecord,
	output slotAddr_t   memAddr,
	output logic        memPlayer,
	output logic        writeEn,
	output shipRecord_t writeRecord,
	output logic        accepted,
	output logic        borderConflict,
	output logic        overlapConflict,
	output logic        conflict
);

	logic        shapeLoad;
	logic        scanStart;
	logic        inBounds;
	logic        scanDone;
	logic        hit;
	shipRecord_t shipRec;
	slotAddr_t   scanAddr;
	slotAddr_t   fleetSize;

	// Fleet pointer doubles as the write slot
	assign memAddr = writeEn ? fleetSize : scanAddr;
	assign memPlayer = req.player;
	assign writeRecord = shipRec;

	placementControl control
	(
		.clk(clk),
		.rstN(rstN),
		.enable(enable),
		.inBounds(inBounds),
		.scanDone(scanDone),
		.hit(hit),
		.shapeLoad(shapeLoad),
		.scanStart(scanStart),
		.writeEn(writeEn),
		.accepted(accepted),
		.borderConflict(borderConflict),
		.overlapConflict(overlapConflict),
		.conflict(conflict)
	);

	shipShaper #(.GridSize(GridSize)) shaper
	(
		.clk(clk),
		.rstN(rstN),
		.shapeLoad(shapeLoad),
		.req(req),
		.shipRec(shipRec),
		.inBounds(inBounds)
	);

	overlapScanner scanner
	(
		.clk(clk),
		.rstN(rstN),
		.scanStart(scanStart),
		.shipRec(shipRec),
		.fleetSize(fleetSize),
		.readRecord(readRecord),
		.memAddr(scanAddr),
		.scanDone(scanDone),
		.hit(hit)
	);

	fleetCounter #(.MaxShips(MaxShips)) counter
	(
		.clk(clk),
		.rstN(rstN),
		.player(req.player),
		.advance(writeEn),
		.fleetSize(fleetSize)
	);

endmodule

// File: sim/shipValidatorTb.sv
`timescale 1ns/1ps

module shipValidatorTb
	import fleetPkg::*;
();

	localparam int GridSize = 9;
	localparam int MaxShips = 20;
	localparam int TimeoutCycles = 64;
	localparam int RequestCount = 300;

	logic        clk = 1'b0;
	logic        rstN;
	logic        enable;
	placeReq_t   req;
	shipRecord_t readRecord = '0;
	slotAddr_t   memAddr;
	logic        memPlayer;
	logic        writeEn;
	shipRecord_t writeRecord;
	logic        accepted;
	logic        borderConflict;
	logic        overlapConflict;
	logic        conflict;

	// Fleet memory and the reference fleets
	shipRecord_t fleetMem [2][32];
	shipRecord_t modelFleet [2][32];
	int          modelSize [2];

	always #5 clk = ~clk;

	shipValidator #(.GridSize(GridSize), .MaxShips(MaxShips)) DUT
	(
		.clk(clk),
		.rstN(rstN),
		.enable(enable),
		.req(req),
		.readRecord(readRecord),
		.memAddr(memAddr),
		.memPlayer(memPlayer),
		.writeEn(writeEn),
		.writeRecord(writeRecord),
		.accepted(accepted),
		.borderConflict(borderConflict),
		.overlapConflict(overlapConflict),
		.conflict(conflict)
	);

	// Registered read port and a write port
	always @(posedge clk)
	begin
		readRecord <= fleetMem[memPlayer][memAddr];
		if (writeEn)
			fleetMem[memPlayer][memAddr] <= writeRecord;
	end

	// ******************************
	// Error handling and compares
	// ******************************
	task automatic abortRun();
		$display("Regression failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkResult(string name, logic got, logic expected);
		if (got !== expected)
		begin
			$display("MISMATCH time %0t %s got %b expected %b", $time, name, got, expected);
			abortRun();
		end
	endtask

	task automatic checkRecord(string name, shipRecord_t got, shipRecord_t expected);
		if (got !== expected)
		begin
			$display("MISMATCH time %0t %s got %h expected %h", $time, name, got, expected);
			abortRun();
		end
	endtask

	task automatic checkSlot(string name, slotAddr_t got, slotAddr_t expected);
		if (got !== expected)
		begin
			$display("MISMATCH time %0t %s got %0d expected %0d", $time, name, got, expected);
			abortRun();
		end
	endtask

	task automatic checkLevels(logic expAccept, logic expBorder, logic expOverlap);
		checkResult("accepted", accepted, expAccept);
		checkResult("borderConflict", borderConflict, expBorder);
		checkResult("overlapConflict", overlapConflict, expOverlap);
		checkResult("conflict", conflict, expBorder | expOverlap);
	endtask

	// ******************************
	// Reference model
	// ******************************
	// Ship cells and the board check from the placement rules
	function automatic shipRecord_t shapeModel(input placeReq_t r, output logic onBoard);
		shipRecord_t rec;
		int len;
		int side;
		int dx;
		int dy;
		int px;
		int py;
		rec = '0;
		rec.shipType = r.shipType;
		onBoard = 1'b1;
		case (r.shipType)
			submarine:  len = 1;
			cruiser:    len = 2;
			seaplane:   len = 3;
			battleship: len = 4;
			carrier:    len = 5;
			default:    len = 0;
		endcase
		if (len == 0)
			onBoard = 1'b0;
		rec.count = cellCount_t'(len);
		side = r.flip ? -1 : 1;
		for (int k = 0; k < len; k++)
		begin
			// Seaplane only bends at its middle cell
			if (r.shipType == seaplane && k == 1)
			begin
				dx = r.vertical ? side : 1;
				dy = r.vertical ? 1 : side;
			end
			else
			begin
				dx = r.vertical ? 0 : k;
				dy = r.vertical ? k : 0;
			end
			px = int'(r.anchor.coordX) + dx;
			py = int'(r.anchor.coordY) + dy;
			if (px < 0 || px >= GridSize || py < 0 || py >= GridSize)
				onBoard = 1'b0;
			rec.cells[k].coordX = coord_t'(px);
			rec.cells[k].coordY = coord_t'(py);
		end
		return rec;
	endfunction

	function automatic logic recordsCollide(shipRecord_t a, shipRecord_t b);
		logic same;
		same = 1'b0;
		for (int i = 0; i < int'(a.count); i++)
			for (int j = 0; j < int'(b.count); j++)
				if (a.cells[i] == b.cells[j])
					same = 1'b1;
		return same;
	endfunction

	// Raw type code so that codes 5 to 7 can be sent too
	function automatic placeReq_t makeRequest(logic player, logic [2:0] code, int x, int y,
		logic vertical, logic flip);
		placeReq_t r;
		r = {player, code, coord_t'(x), coord_t'(y), vertical, flip};
		return r;
	endfunction

	function automatic placeReq_t randomRequest(logic player);
		shipRecord_t old;
		cell_t       pick;
		int          x;
		int          y;
		x = int'($urandom_range(15, 0));
		y = int'($urandom_range(15, 0));
		// Aim at a stored cell for about 40% of the requests
		if (modelSize[player] > 0 && $urandom_range(99, 0) < 40)
		begin
			old = modelFleet[player][$urandom_range(modelSize[player] - 1, 0)];
			pick = old.cells[$urandom_range(int'(old.count) - 1, 0)];
			x = int'(pick.coordX);
			y = int'(pick.coordY);
		end
		return makeRequest(player, 3'($urandom_range(7, 0)), x, y,
			1'($urandom_range(1, 0)), 1'($urandom_range(1, 0)));
	endfunction

	// ******************************
	// One request from start to release
	// ******************************
	task automatic runRequest(input placeReq_t r);
		shipRecord_t expRec;
		logic        onBoard;
		logic        expOverlap;
		logic        expAccept;
		int          waited;
		int          holdCycles;
		expRec = shapeModel(r, onBoard);
		expOverlap = 1'b0;
		if (onBoard)
			for (int k = 0; k < modelSize[r.player]; k++)
				if (recordsCollide(expRec, modelFleet[r.player][k]))
					expOverlap = 1'b1;
		expAccept = onBoard && !expOverlap;

		@(posedge clk);
		req <= r;
		enable <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (!(accepted || borderConflict || overlapConflict))
		begin
			checkResult("writeEn", writeEn, 1'b0);
			waited++;
			if (waited >= TimeoutCycles)
			begin
				$display("Timeout: no result level rose within %0d cycles", TimeoutCycles);
				abortRun();
			end
			@(negedge clk);
		end

		checkLevels(expAccept, !onBoard, expOverlap);
		checkResult("writeEn", writeEn, expAccept);
		if (expAccept)
		begin
			checkRecord("writeRecord", writeRecord, expRec);
			checkSlot("memAddr", memAddr, slotAddr_t'(modelSize[r.player]));
			checkResult("memPlayer", memPlayer, r.player);
			modelFleet[r.player][modelSize[r.player]] = expRec;
			modelSize[r.player]++;
		end

		// Result held while enable stays high
		holdCycles = int'($urandom_range(3, 0));
		repeat (holdCycles)
		begin
			@(negedge clk);
			checkLevels(expAccept, !onBoard, expOverlap);
			checkResult("writeEn", writeEn, 1'b0);
		end

		@(posedge clk);
		enable <= 1'b0;
		@(negedge clk);
		checkLevels(expAccept, !onBoard, expOverlap);
		checkResult("writeEn", writeEn, 1'b0);
		@(negedge clk);
		checkLevels(1'b0, 1'b0, 1'b0);
		checkResult("writeEn", writeEn, 1'b0);
	endtask

	initial
	begin
		int player;
		void'($urandom(35178));
		rstN <= 1'b0;
		enable <= 1'b0;
		req <= '0;
		modelSize[0] = 0;
		modelSize[1] = 0;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;

		// Quiet outputs after reset
		repeat (3)
		begin
			@(negedge clk);
			checkLevels(1'b0, 1'b0, 1'b0);
			checkResult("writeEn", writeEn, 1'b0);
		end

		// Directed cases first
		runRequest(makeRequest(1'b0, 3'd1, 2, 2, 1'b1, 1'b0));
		runRequest(makeRequest(1'b0, 3'd0, 2, 3, 1'b0, 1'b0));
		runRequest(makeRequest(1'b1, 3'd0, 2, 3, 1'b0, 1'b0));
		runRequest(makeRequest(1'b0, 3'd4, 6, 0, 1'b0, 1'b0));
		runRequest(makeRequest(1'b1, 3'd6, 0, 0, 1'b0, 1'b0));
		runRequest(makeRequest(1'b0, 3'd2, 0, 0, 1'b1, 1'b1));
		runRequest(makeRequest(1'b0, 3'd2, 4, 5, 1'b0, 1'b1));

		for (int n = 0; n < RequestCount; n++)
		begin
			player = int'($urandom_range(1, 0));
			// Keep each fleet below its last slot
			if (modelSize[player] >= MaxShips - 1)
				player = 1 - player;
			if (modelSize[player] >= MaxShips - 1)
				break;
			runRequest(randomRequest(1'(player)));
		end

		$display("Regression passed");
		$finish;
	end

endmodule

// File: compile.f
source/fleetPkg.sv
source/shipShaper.sv
source/overlapScanner.sv
source/fleetCounter.sv
source/placementControl.sv
source/shipValidator.sv
sim/shipValidatorTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= shipValidatorTb
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert
PASS_TEXT ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
